// ==== dma_rd_xbar.f ====
rtl/dma_rd_pkg.sv
rtl/rst_sync_pipe.sv
rtl/rd_arb_fsm.sv
rtl/beat_counter.sv
rtl/ddr_addr_map.sv
rtl/rd_data_route.sv
rtl/dma_rd_xbar.sv
test/tb_clk_gen.sv
test/tb_checker.sv
test/tb_dma_rd_xbar.sv

// ==== rtl/beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter (
	input  logic                         clk,
	input  logic                         rst_sync_n,
	input  logic                         load,
	input  logic [dma_rd_pkg::LEN_W-1:0] len,
	input  logic                         beat_fire,
	output logic                         last_beat
);
	import dma_rd_pkg::*;

	logic [LEN_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (!rst_sync_n) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= '0;
		end else if (beat_fire) begin
			cnt <= cnt + 1'b1;
		end
	end

	// len is beats minus one
	assign last_beat = (cnt == len);

endmodule

// ==== rtl/ddr_addr_map.sv ====
`timescale 1ns/1ps

module ddr_addr_map (
	input  logic                          clk,
	input  logic                          rst_sync_n,
	input  logic                          ar_take,
	input  dma_rd_pkg::src_t              grant_src,
	input  logic [dma_rd_pkg::ADDR_W-1:0] dma_ar_addr,
	input  logic [dma_rd_pkg::ID_W-1:0]   dma_ar_id,
	input  logic [dma_rd_pkg::LEN_W-1:0]  dma_ar_len,
	input  logic [dma_rd_pkg::ADDR_W-1:0] mrd_ar_addr,
	input  logic [dma_rd_pkg::ID_W-1:0]   mrd_ar_id,
	input  logic [dma_rd_pkg::LEN_W-1:0]  mrd_ar_len,
	output logic [dma_rd_pkg::N_CH-1:0]   ddr_ar_valid,
	output logic [dma_rd_pkg::ADDR_W-1:0] ddr_ar_addr,
	output logic [dma_rd_pkg::XID_W-1:0]  ddr_ar_id,
	output logic [dma_rd_pkg::LEN_W-1:0]  ddr_ar_len,
	input  logic [dma_rd_pkg::N_CH-1:0]   ddr_ar_ready,
	output logic                          ar_done,
	output dma_rd_pkg::ch_sel_t           req_ch,
	output logic [dma_rd_pkg::LEN_W-1:0]  req_len
);
	import dma_rd_pkg::*;

	ddr_addr_u        in_addr;
	ddr_addr_u        req_addr;
	ddr_addr_u        out_addr;
	logic [ID_W-1:0]  req_id;
	logic             ar_pend;

	// alias bit dropped on entry
	always_comb begin
		in_addr.flat          = (grant_src == SRC_MRD) ? mrd_ar_addr : dma_ar_addr;
		in_addr.fld.alias_bit = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (ar_take) begin
			req_addr <= in_addr;
			req_id   <= (grant_src == SRC_MRD) ? mrd_ar_id : dma_ar_id;
			req_len  <= (grant_src == SRC_MRD) ? mrd_ar_len : dma_ar_len;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_sync_n) begin
			ar_pend <= 1'b0;
		end else if (ar_take) begin
			ar_pend <= 1'b1;
		end else if (ar_done) begin
			ar_pend <= 1'b0;
		end
	end

	// channel select bits cleared on the way out
	always_comb begin
		out_addr            = req_addr;
		out_addr.fld.ch_sel = '0;
	end

	assign req_ch       = req_addr.fld.ch_sel;
	assign ddr_ar_valid = {{(N_CH-1){1'b0}}, ar_pend} << req_ch;
	assign ddr_ar_addr  = out_addr.flat;
	assign ddr_ar_id    = {grant_src, req_id};
	assign ddr_ar_len   = req_len;
	assign ar_done      = ar_pend && ddr_ar_ready[req_ch];

endmodule

// ==== rtl/dma_rd_pkg.sv ====
package dma_rd_pkg;

	localparam int ADDR_W     = 64;
	localparam int DATA_W     = 64;
	localparam int ID_W       = 6;
	localparam int XID_W      = ID_W + 1;
	localparam int LEN_W      = 8;
	localparam int N_CH       = 4;
	localparam int RST_STAGES = 4;

	// arbiter states
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ADDR = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;

	typedef logic [1:0] ch_sel_t;

	// top bit of the ddr side id
	typedef enum logic {
		SRC_DMA = 1'b0,
		SRC_MRD = 1'b1
	} src_t;

	// bit 36 aliases the host window, bits 35:34 pick the channel
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		struct packed {
			logic [26:0] hi;
			logic        alias_bit;
			ch_sel_t     ch_sel;
			logic [33:0] offset;
		} fld;
	} ddr_addr_u;

endpackage

// ==== rtl/dma_rd_xbar.sv ====
`timescale 1ns/1ps

module dma_rd_xbar (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          dma_ar_valid,
	output logic                          dma_ar_ready,
	input  logic [dma_rd_pkg::ADDR_W-1:0] dma_ar_addr,
	input  logic [dma_rd_pkg::ID_W-1:0]   dma_ar_id,
	input  logic [dma_rd_pkg::LEN_W-1:0]  dma_ar_len,
	output logic                          dma_r_valid,
	input  logic                          dma_r_ready,
	output logic [dma_rd_pkg::DATA_W-1:0] dma_r_data,
	output logic [dma_rd_pkg::ID_W-1:0]   dma_r_id,
	output logic                          dma_r_last,
	input  logic                          mrd_ar_valid,
	output logic                          mrd_ar_ready,
	input  logic [dma_rd_pkg::ADDR_W-1:0] mrd_ar_addr,
	input  logic [dma_rd_pkg::ID_W-1:0]   mrd_ar_id,
	input  logic [dma_rd_pkg::LEN_W-1:0]  mrd_ar_len,
	output logic                          mrd_r_valid,
	input  logic                          mrd_r_ready,
	output logic [dma_rd_pkg::DATA_W-1:0] mrd_r_data,
	output logic [dma_rd_pkg::ID_W-1:0]   mrd_r_id,
	output logic                          mrd_r_last,
	output logic [dma_rd_pkg::N_CH-1:0]   ddr_ar_valid,
	input  logic [dma_rd_pkg::N_CH-1:0]   ddr_ar_ready,
	output logic [dma_rd_pkg::ADDR_W-1:0] ddr_ar_addr,
	output logic [dma_rd_pkg::XID_W-1:0]  ddr_ar_id,
	output logic [dma_rd_pkg::LEN_W-1:0]  ddr_ar_len,
	input  logic [dma_rd_pkg::N_CH-1:0]   ddr_r_valid,
	output logic [dma_rd_pkg::N_CH-1:0]   ddr_r_ready,
	input  logic [dma_rd_pkg::DATA_W-1:0] ddr_r_data [dma_rd_pkg::N_CH],
	input  logic [dma_rd_pkg::XID_W-1:0]  ddr_r_id [dma_rd_pkg::N_CH]
);
	import dma_rd_pkg::*;

	logic             rst_sync_n;
	logic             ar_take;
	logic             ar_done;
	logic             busy;
	logic             beat_fire;
	logic             last_beat;
	src_t             grant_src;
	ch_sel_t          req_ch;
	logic [LEN_W-1:0] req_len;

	rst_sync_pipe i_rst_sync_pipe (
		.clk        (clk),
		.rst_n      (rst_n),
		.rst_sync_n (rst_sync_n)
	);

	rd_arb_fsm i_rd_arb_fsm (
		.clk          (clk),
		.rst_sync_n   (rst_sync_n),
		.dma_ar_valid (dma_ar_valid),
		.mrd_ar_valid (mrd_ar_valid),
		.dma_ar_ready (dma_ar_ready),
		.mrd_ar_ready (mrd_ar_ready),
		.ar_take      (ar_take),
		.grant_src    (grant_src),
		.ar_done      (ar_done),
		.last_beat    (last_beat),
		.beat_fire    (beat_fire),
		.busy         (busy)
	);

	beat_counter i_beat_counter (
		.clk        (clk),
		.rst_sync_n (rst_sync_n),
		.load       (ar_take),
		.len        (req_len),
		.beat_fire  (beat_fire),
		.last_beat  (last_beat)
	);

	ddr_addr_map i_ddr_addr_map (
		.clk          (clk),
		.rst_sync_n   (rst_sync_n),
		.ar_take      (ar_take),
		.grant_src    (grant_src),
		.dma_ar_addr  (dma_ar_addr),
		.dma_ar_id    (dma_ar_id),
		.dma_ar_len   (dma_ar_len),
		.mrd_ar_addr  (mrd_ar_addr),
		.mrd_ar_id    (mrd_ar_id),
		.mrd_ar_len   (mrd_ar_len),
		.ddr_ar_valid (ddr_ar_valid),
		.ddr_ar_addr  (ddr_ar_addr),
		.ddr_ar_id    (ddr_ar_id),
		.ddr_ar_len   (ddr_ar_len),
		.ddr_ar_ready (ddr_ar_ready),
		.ar_done      (ar_done),
		.req_ch       (req_ch),
		.req_len      (req_len)
	);

	rd_data_route i_rd_data_route (
		.req_ch      (req_ch),
		.grant_src   (grant_src),
		.busy        (busy),
		.ddr_r_valid (ddr_r_valid),
		.ddr_r_data  (ddr_r_data),
		.ddr_r_id    (ddr_r_id),
		.ddr_r_ready (ddr_r_ready),
		.dma_r_valid (dma_r_valid),
		.dma_r_data  (dma_r_data),
		.dma_r_id    (dma_r_id),
		.dma_r_last  (dma_r_last),
		.dma_r_ready (dma_r_ready),
		.mrd_r_valid (mrd_r_valid),
		.mrd_r_data  (mrd_r_data),
		.mrd_r_id    (mrd_r_id),
		.mrd_r_last  (mrd_r_last),
		.mrd_r_ready (mrd_r_ready),
		.beat_fire   (beat_fire),
		.last_beat   (last_beat)
	);

endmodule

// ==== rtl/rd_arb_fsm.sv ====
`timescale 1ns/1ps

module rd_arb_fsm (
	input  logic             clk,
	input  logic             rst_sync_n,
	input  logic             dma_ar_valid,
	input  logic             mrd_ar_valid,
	output logic             dma_ar_ready,
	output logic             mrd_ar_ready,
	output logic             ar_take,
	output dma_rd_pkg::src_t grant_src,
	input  logic             ar_done,
	input  logic             last_beat,
	input  logic             beat_fire,
	output logic             busy
);
	import dma_rd_pkg::*;

	logic [1:0] state;
	logic       run;
	src_t       grant_q;
	src_t       win_src;

	// on a tie the master not granted last wins
	always_comb begin
		if (dma_ar_valid && mrd_ar_valid) begin
			if (grant_q == SRC_DMA) begin
				win_src = SRC_MRD;
			end else begin
				win_src = SRC_DMA;
			end
		end else if (mrd_ar_valid) begin
			win_src = SRC_MRD;
		end else begin
			win_src = SRC_DMA;
		end
	end

	assign ar_take      = run && (state == ST_IDLE) && (dma_ar_valid || mrd_ar_valid);
	assign dma_ar_ready = ar_take && (win_src == SRC_DMA);
	assign mrd_ar_ready = ar_take && (win_src == SRC_MRD);
	assign grant_src    = (state == ST_IDLE) ? win_src : grant_q;
	assign busy         = (state == ST_DATA);

	always_ff @(posedge clk) begin
		if (!rst_sync_n) begin
			state   <= ST_IDLE;
			run     <= 1'b0;
			grant_q <= SRC_MRD;
		end else begin
			run <= 1'b1;
			case (state)
				ST_IDLE: begin
					if (ar_take) begin
						state   <= ST_ADDR;
						grant_q <= win_src;
					end
				end
				ST_ADDR: begin
					if (ar_done) begin
						state <= ST_DATA;
					end
				end
				ST_DATA: begin
					// grant held until the final beat moves
					if (last_beat && beat_fire) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== rtl/rd_data_route.sv ====
`timescale 1ns/1ps

module rd_data_route (
	input  dma_rd_pkg::ch_sel_t           req_ch,
	input  dma_rd_pkg::src_t              grant_src,
	input  logic                          busy,
	input  logic [dma_rd_pkg::N_CH-1:0]   ddr_r_valid,
	input  logic [dma_rd_pkg::DATA_W-1:0] ddr_r_data [dma_rd_pkg::N_CH],
	input  logic [dma_rd_pkg::XID_W-1:0]  ddr_r_id [dma_rd_pkg::N_CH],
	output logic [dma_rd_pkg::N_CH-1:0]   ddr_r_ready,
	output logic                          dma_r_valid,
	output logic [dma_rd_pkg::DATA_W-1:0] dma_r_data,
	output logic [dma_rd_pkg::ID_W-1:0]   dma_r_id,
	output logic                          dma_r_last,
	input  logic                          dma_r_ready,
	output logic                          mrd_r_valid,
	output logic [dma_rd_pkg::DATA_W-1:0] mrd_r_data,
	output logic [dma_rd_pkg::ID_W-1:0]   mrd_r_id,
	output logic                          mrd_r_last,
	input  logic                          mrd_r_ready,
	output logic                          beat_fire,
	input  logic                          last_beat
);
	import dma_rd_pkg::*;

	logic             to_mrd;
	logic             sel_valid;
	logic             mst_ready;
	logic [XID_W-1:0] sel_xid;

	assign to_mrd    = (grant_src == SRC_MRD);
	assign sel_valid = busy && ddr_r_valid[req_ch];
	assign sel_xid   = ddr_r_id[req_ch];
	assign mst_ready = to_mrd ? mrd_r_ready : dma_r_ready;

	assign dma_r_valid = sel_valid && !to_mrd;
	assign mrd_r_valid = sel_valid && to_mrd;

	// source bit stripped, only the master id goes back
	assign dma_r_data = ddr_r_data[req_ch];
	assign dma_r_id   = sel_xid[ID_W-1:0];
	assign dma_r_last = last_beat;
	assign mrd_r_data = ddr_r_data[req_ch];
	assign mrd_r_id   = sel_xid[ID_W-1:0];
	assign mrd_r_last = last_beat;

	// back-pressure reaches the active channel only
	assign ddr_r_ready = {{(N_CH-1){1'b0}}, busy && mst_ready} << req_ch;
	assign beat_fire   = sel_valid && mst_ready;

endmodule

// ==== rtl/rst_sync_pipe.sv ====
`timescale 1ns/1ps

module rst_sync_pipe (
	input  logic clk,
	input  logic rst_n,
	output logic rst_sync_n
);
	import dma_rd_pkg::*;

	logic [RST_STAGES-1:0] pipe;

	// ones shift in after release
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pipe <= '0;
		end else begin
			pipe <= {pipe[RST_STAGES-2:0], 1'b1};
		end
	end

	assign rst_sync_n = pipe[RST_STAGES-1];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_dma_rd_xbar -f dma_rd_xbar.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

// ==== test/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [1:0]                    ar_valid,
	input  logic [1:0]                    ar_ready,
	input  logic [dma_rd_pkg::ADDR_W-1:0] ar_addr [2],
	input  logic [dma_rd_pkg::ID_W-1:0]   ar_id [2],
	input  logic [dma_rd_pkg::LEN_W-1:0]  ar_len [2],
	input  logic [dma_rd_pkg::N_CH-1:0]   ddr_ar_valid,
	input  logic [dma_rd_pkg::N_CH-1:0]   ddr_ar_ready,
	input  logic [dma_rd_pkg::ADDR_W-1:0] ddr_ar_addr,
	input  logic [dma_rd_pkg::XID_W-1:0]  ddr_ar_id,
	input  logic [dma_rd_pkg::LEN_W-1:0]  ddr_ar_len,
	input  logic [dma_rd_pkg::N_CH-1:0]   ddr_r_ready,
	input  logic [1:0]                    r_valid,
	input  logic [1:0]                    r_ready,
	input  logic [dma_rd_pkg::DATA_W-1:0] r_data [2],
	input  logic [dma_rd_pkg::ID_W-1:0]   r_id [2],
	input  logic [1:0]                    r_last,
	output int                            err_cnt,
	output int                            burst_cnt,
	output int                            beat_cnt,
	output int                            open_cnt
);
	import dma_rd_pkg::*;

	// bits 36:34 never reach a ddr channel
	localparam logic [ADDR_W-1:0] MAP_MASK = 64'h0000_001c_0000_0000;

	logic [ADDR_W-1:0] q_addr [2][$];
	logic [ID_W-1:0]   q_id [2][$];
	logic [LEN_W-1:0]  q_len [2][$];
	int                beat_idx [2];
	int                rel_cnt;
	int                last_grant;
	logic              have_grant;
	logic              exp_pend;
	logic [1:0]        exp_ch;
	logic [ADDR_W-1:0] exp_addr;
	logic [XID_W-1:0]  exp_xid;
	logic [LEN_W-1:0]  exp_len;

	initial begin
		err_cnt     = 0;
		burst_cnt   = 0;
		beat_cnt    = 0;
		open_cnt    = 0;
		rel_cnt     = 0;
		last_grant  = 0;
		have_grant  = 1'b0;
		exp_pend    = 1'b0;
		beat_idx[0] = 0;
		beat_idx[1] = 0;
	end

	task automatic check_value(input string sig, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERROR t=%0t %s got %0h expected %0h", $time, sig, got, exp);
			err_cnt++;
		end
	endtask

	task automatic report_fault(input string what);
		$display("failure at t=%0t: %s", $time, what);
		err_cnt++;
	endtask

	// everything is sampled mid-cycle, one half period before the edge that moves it
	always @(negedge clk) begin : watch
		logic [ADDR_W-1:0] mapped;
		string             pfx;

		if (!rst_n || rel_cnt < RST_STAGES) begin
			if ((|{ar_ready, ddr_ar_valid, ddr_r_ready, r_valid}) === 1'b1) begin
				report_fault("ready or valid output high during reset");
			end
		end
		if (!rst_n) begin
			rel_cnt = 0;
		end else begin
			rel_cnt++;
		end

		if ((|ddr_ar_valid) === 1'b1) begin
			if (!exp_pend) begin
				report_fault("ddr request without an accepted master request");
			end else begin
				check_value("ddr_ar_valid", ddr_ar_valid, N_CH'(1) << exp_ch);
				check_value("ddr_ar_addr", ddr_ar_addr, exp_addr);
				check_value("ddr_ar_id", ddr_ar_id, exp_xid);
				check_value("ddr_ar_len", ddr_ar_len, exp_len);
				if ((ddr_ar_valid & ddr_ar_ready) != '0) begin
					exp_pend = 1'b0;
					burst_cnt++;
				end
			end
		end

		if (ar_ready == 2'b11) begin
			report_fault("both masters granted in the same cycle");
		end
		// tie while idle goes to the master not granted last
		if (ar_valid == 2'b11 && ar_ready != 2'b00 && have_grant) begin
			if (ar_ready[last_grant]) begin
				report_fault("tie granted to the previous winner again");
			end
		end
		for (int m = 0; m < 2; m++) begin
			if (ar_valid[m] && ar_ready[m]) begin
				mapped = ar_addr[m] & ~MAP_MASK;
				q_addr[m].push_back(mapped);
				q_id[m].push_back(ar_id[m]);
				q_len[m].push_back(ar_len[m]);
				exp_pend   = 1'b1;
				exp_ch     = ar_addr[m][35:34];
				exp_addr   = mapped;
				exp_xid    = {m[0], ar_id[m]};
				exp_len    = ar_len[m];
				have_grant = 1'b1;
				last_grant = m;
			end
		end

		for (int m = 0; m < 2; m++) begin
			pfx = (m == 0) ? "dma" : "mrd";
			if (r_valid[m] && r_ready[m]) begin
				if (q_addr[m].size() == 0) begin
					report_fault({pfx, " master got a beat with no open burst"});
				end else begin
					check_value({pfx, "_r_data"}, r_data[m],
						q_addr[m][0] ^ DATA_W'(beat_idx[m]));
					check_value({pfx, "_r_id"}, r_id[m], q_id[m][0]);
					check_value({pfx, "_r_last"}, r_last[m], beat_idx[m] == q_len[m][0]);
					beat_cnt++;
					if (beat_idx[m] == int'(q_len[m][0])) begin
						void'(q_addr[m].pop_front());
						void'(q_id[m].pop_front());
						void'(q_len[m].pop_front());
						beat_idx[m] = 0;
					end else begin
						beat_idx[m]++;
					end
				end
			end
		end
		open_cnt = q_addr[0].size() + q_addr[1].size();
	end

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter real PERIOD_NS = 100.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

endmodule

// ==== test/tb_dma_rd_xbar.sv ====
`timescale 1ns/1ps

module tb_dma_rd_xbar;
	import dma_rd_pkg::*;

	localparam int N_REQ      = 40;
	localparam int WAIT_LIMIT = 2000;

	logic   clk;
	logic   rst_n;
	integer seed;
	int     timeouts;
	int     err_cnt;
	int     burst_cnt;
	int     beat_cnt;
	int     open_cnt;

	// index 0 is the host dma port and 1 the memory reader
	logic [1:0]        m_ar_valid;
	logic [1:0]        m_ar_ready;
	logic [ADDR_W-1:0] m_ar_addr [2];
	logic [ID_W-1:0]   m_ar_id [2];
	logic [LEN_W-1:0]  m_ar_len [2];
	logic [1:0]        m_r_valid;
	logic [1:0]        m_r_ready;
	logic [DATA_W-1:0] m_r_data [2];
	logic [ID_W-1:0]   m_r_id [2];
	logic [1:0]        m_r_last;

	logic [N_CH-1:0]   ddr_ar_valid;
	logic [N_CH-1:0]   ddr_ar_ready;
	logic [ADDR_W-1:0] ddr_ar_addr;
	logic [XID_W-1:0]  ddr_ar_id;
	logic [LEN_W-1:0]  ddr_ar_len;
	logic [N_CH-1:0]   ddr_r_valid;
	logic [N_CH-1:0]   ddr_r_ready;
	logic [DATA_W-1:0] ddr_r_data [N_CH];
	logic [XID_W-1:0]  ddr_r_id [N_CH];

	// ddr channel models
	logic [N_CH-1:0]   smp_ar_valid;
	logic [ADDR_W-1:0] smp_ar_addr;
	logic [XID_W-1:0]  smp_ar_id;
	logic [LEN_W-1:0]  smp_ar_len;
	logic [N_CH-1:0]   smp_r_ready;
	logic              ch_active [N_CH];
	logic [ADDR_W-1:0] ch_addr [N_CH];
	logic [XID_W-1:0]  ch_id [N_CH];
	logic [LEN_W-1:0]  ch_len [N_CH];
	logic [LEN_W-1:0]  ch_beat [N_CH];

	tb_clk_gen #(
		.PERIOD_NS (100.0)
	) i_tb_clk_gen (
		.clk (clk)
	);

	dma_rd_xbar i_dma_rd_xbar (
		.clk          (clk),
		.rst_n        (rst_n),
		.dma_ar_valid (m_ar_valid[0]),
		.dma_ar_ready (m_ar_ready[0]),
		.dma_ar_addr  (m_ar_addr[0]),
		.dma_ar_id    (m_ar_id[0]),
		.dma_ar_len   (m_ar_len[0]),
		.dma_r_valid  (m_r_valid[0]),
		.dma_r_ready  (m_r_ready[0]),
		.dma_r_data   (m_r_data[0]),
		.dma_r_id     (m_r_id[0]),
		.dma_r_last   (m_r_last[0]),
		.mrd_ar_valid (m_ar_valid[1]),
		.mrd_ar_ready (m_ar_ready[1]),
		.mrd_ar_addr  (m_ar_addr[1]),
		.mrd_ar_id    (m_ar_id[1]),
		.mrd_ar_len   (m_ar_len[1]),
		.mrd_r_valid  (m_r_valid[1]),
		.mrd_r_ready  (m_r_ready[1]),
		.mrd_r_data   (m_r_data[1]),
		.mrd_r_id     (m_r_id[1]),
		.mrd_r_last   (m_r_last[1]),
		.ddr_ar_valid (ddr_ar_valid),
		.ddr_ar_ready (ddr_ar_ready),
		.ddr_ar_addr  (ddr_ar_addr),
		.ddr_ar_id    (ddr_ar_id),
		.ddr_ar_len   (ddr_ar_len),
		.ddr_r_valid  (ddr_r_valid),
		.ddr_r_ready  (ddr_r_ready),
		.ddr_r_data   (ddr_r_data),
		.ddr_r_id     (ddr_r_id)
	);

	tb_checker i_tb_checker (
		.clk          (clk),
		.rst_n        (rst_n),
		.ar_valid     (m_ar_valid),
		.ar_ready     (m_ar_ready),
		.ar_addr      (m_ar_addr),
		.ar_id        (m_ar_id),
		.ar_len       (m_ar_len),
		.ddr_ar_valid (ddr_ar_valid),
		.ddr_ar_ready (ddr_ar_ready),
		.ddr_ar_addr  (ddr_ar_addr),
		.ddr_ar_id    (ddr_ar_id),
		.ddr_ar_len   (ddr_ar_len),
		.ddr_r_ready  (ddr_r_ready),
		.r_valid      (m_r_valid),
		.r_ready      (m_r_ready),
		.r_data       (m_r_data),
		.r_id         (m_r_id),
		.r_last       (m_r_last),
		.err_cnt      (err_cnt),
		.burst_cnt    (burst_cnt),
		.beat_cnt     (beat_cnt),
		.open_cnt     (open_cnt)
	);

	// one request at a time and then its whole burst
	task automatic run_master(input int m);
		int n;
		int cnt;
		for (n = 0; n < N_REQ; n++) begin
			repeat (2'($random(seed))) @(posedge clk);
			m_ar_addr[m]  <= {$random(seed), $random(seed)};
			m_ar_id[m]    <= ID_W'($random(seed));
			m_ar_len[m]   <= LEN_W'($random(seed) & 7);
			m_ar_valid[m] <= 1'b1;
			cnt = 0;
			@(negedge clk);
			while (!m_ar_ready[m] && cnt < WAIT_LIMIT) begin
				@(negedge clk);
				cnt++;
			end
			@(posedge clk);
			m_ar_valid[m] <= 1'b0;
			if (cnt >= WAIT_LIMIT) begin
				$display("timeout: master %0d request was never accepted", m);
				timeouts++;
				return;
			end
			cnt = 0;
			@(negedge clk);
			while (!(m_r_valid[m] && m_r_ready[m] && m_r_last[m]) && cnt < WAIT_LIMIT) begin
				@(negedge clk);
				cnt++;
			end
			@(posedge clk);
			if (cnt >= WAIT_LIMIT) begin
				$display("timeout: master %0d burst never finished", m);
				timeouts++;
				return;
			end
		end
	endtask

	// toggles through reset as well
	always @(posedge clk) begin
		m_r_ready <= 2'($random(seed));
	end

	always @(negedge clk) begin
		smp_ar_valid = ddr_ar_valid;
		smp_ar_addr  = ddr_ar_addr;
		smp_ar_id    = ddr_ar_id;
		smp_ar_len   = ddr_ar_len;
		smp_r_ready  = ddr_r_ready;
	end

	always @(posedge clk) begin
		for (int c = 0; c < N_CH; c++) begin
			if (!rst_n) begin
				ddr_ar_ready[c] <= 1'b0;
				ddr_r_valid[c]  <= 1'b0;
				ch_active[c] = 1'b0;
			end else begin
				if (smp_ar_valid[c] && ddr_ar_ready[c]) begin
					ddr_ar_ready[c] <= 1'b0;
					ch_active[c] = 1'b1;
					ch_addr[c]   = smp_ar_addr;
					ch_id[c]     = smp_ar_id;
					ch_len[c]    = smp_ar_len;
					ch_beat[c]   = '0;
				end else if (smp_ar_valid[c] && !ch_active[c]) begin
					// random accept delay
					ddr_ar_ready[c] <= (($random(seed) & 3) == 0);
				end
				if (ddr_r_valid[c] && smp_r_ready[c]) begin
					if (ch_beat[c] == ch_len[c]) begin
						ch_active[c] = 1'b0;
					end
					ch_beat[c] = ch_beat[c] + 1'b1;
				end
				if (ch_active[c] && (!ddr_r_valid[c] || smp_r_ready[c])) begin
					ddr_r_valid[c] <= (($random(seed) & 1) == 1);
					ddr_r_data[c]  <= ch_addr[c] ^ DATA_W'(ch_beat[c]);
					ddr_r_id[c]    <= ch_id[c];
				end else if (!ch_active[c]) begin
					ddr_r_valid[c] <= 1'b0;
				end
			end
		end
	end

	initial begin
		seed         = 45;
		timeouts     = 0;
		rst_n        = 1'b0;
		m_ar_valid   = 2'b00;
		m_r_ready    = 2'b00;
		ddr_ar_ready = '0;
		ddr_r_valid  = '0;
		for (int m = 0; m < 2; m++) begin
			m_ar_addr[m] = '0;
			m_ar_id[m]   = '0;
			m_ar_len[m]  = '0;
		end
		for (int c = 0; c < N_CH; c++) begin
			ddr_r_data[c] = '0;
			ddr_r_id[c]   = '0;
			ch_active[c]  = 1'b0;
		end
		// masters already request while reset is held
		fork
			run_master(0);
			run_master(1);
			begin
				repeat (16) @(posedge clk);
				rst_n <= 1'b1;
			end
		join
		repeat (10) @(posedge clk);
		if (timeouts == 0 && burst_cnt != 2 * N_REQ) begin
			$display("burst count is %0d instead of %0d", burst_cnt, 2 * N_REQ);
		end
		$display("errors %0d, timeouts %0d, open bursts %0d, bursts %0d, beats %0d",
			err_cnt, timeouts, open_cnt, burst_cnt, beat_cnt);
		if (err_cnt == 0 && timeouts == 0 && open_cnt == 0 && burst_cnt == 2 * N_REQ) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
